// ==== verilog/nabp_defines.svh ====
`ifndef NABP_DEFINES_SVH
`define NABP_DEFINES_SVH

// geometry of one run
`define NABP_IMAGE_SIZE 8
`define NABP_LINE_LEN 16
`define NABP_NUM_PE 2
`define NABP_TAP_STEP 4

// fixed-point accumulator split
`define NABP_ACCU_INT 4
`define NABP_ACCU_FRAC 8

// AXI4-Lite bus widths
`define NABP_AXI_ADDR_W 8
`define NABP_AXI_DATA_W 32

// register offsets, byte addressed
`define NABP_REG_CTRL 'h00
`define NABP_REG_BASE 'h04
`define NABP_REG_STATUS 'h08
`define NABP_REG_SAMPLE 'h40
`define NABP_REG_RESULT 'h80

`endif

// ==== verilog/nabp_pkg.sv ====
`default_nettype none

`include "nabp_defines.svh"

package nabp_pkg;

    typedef logic [15:0] sample_t;

    // line index, wraps modulo the line length
    typedef logic [$clog2(`NABP_LINE_LEN)-1:0] ptr_t;

    // unsigned fixed point, integer part on top
    typedef logic [`NABP_ACCU_INT+`NABP_ACCU_FRAC-1:0] accu_t;

    typedef logic [31:0] pix_sum_t;

    typedef logic [$clog2(`NABP_IMAGE_SIZE)-1:0] cnt_t;

    // one tap per PE
    typedef sample_t [`NABP_NUM_PE-1:0] tap_vec_t;

    typedef enum logic [1:0] {ready_s, fill_s, fill_done_s, shift_s} shifter_state_t;

    typedef enum logic [1:0] {
        ctrl_idle_s,
        ctrl_fill_s,
        ctrl_shift_s,
        ctrl_done_s
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/nabp_shift_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface nabp_shift_if;

    // clear pulse at fill start
    logic kick;
    // pointer advance, undelayed
    logic mp_shift_en;
    // pointer advance seen one cycle later
    logic lb_shift_en;
    // tap valid at the PE inputs
    logic pe_en;
    // end of shift, aligned with the last pe_en
    logic done;

    modport source (output kick, mp_shift_en, lb_shift_en, pe_en, done);

    modport line_buffer (input kick, mp_shift_en);

    modport pe (input kick, pe_en);

endinterface

`default_nettype wire

// ==== verilog/nabp_ctrl_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nabp_defines.svh"

module nabp_ctrl_regs
    import nabp_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [`NABP_AXI_ADDR_W-1:0]   awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [`NABP_AXI_DATA_W-1:0]   wdata,
    input  logic [`NABP_AXI_DATA_W/8-1:0] wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [`NABP_AXI_ADDR_W-1:0]   araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [`NABP_AXI_DATA_W-1:0]   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output logic                          fill_kick,
    output logic                          shift_kick,
    output accu_t                         accu_base,
    input  logic                          fill_done,
    input  logic                          shift_done,
    output logic                          sample_we,
    output ptr_t                          sample_addr,
    output sample_t                       sample_data,
    input  pix_sum_t [`NABP_NUM_PE-1:0]   sums
);

    localparam int AW = `NABP_AXI_ADDR_W;
    localparam int DW = `NABP_AXI_DATA_W;
    localparam int PE_SEL_W = (`NABP_NUM_PE > 1) ? $clog2(`NABP_NUM_PE) : 1;

    localparam logic [AW-1:0] CTRL_ADDR = AW'(`NABP_REG_CTRL);
    localparam logic [AW-1:0] BASE_ADDR = AW'(`NABP_REG_BASE);
    localparam logic [AW-1:0] STATUS_ADDR = AW'(`NABP_REG_STATUS);
    localparam logic [AW-1:0] SAMPLE_ADDR = AW'(`NABP_REG_SAMPLE);
    localparam logic [AW-1:0] SAMPLE_END = AW'(`NABP_REG_SAMPLE + 4 * `NABP_LINE_LEN);
    localparam logic [AW-1:0] RESULT_ADDR = AW'(`NABP_REG_RESULT);
    localparam logic [AW-1:0] RESULT_END = AW'(`NABP_REG_RESULT + 4 * `NABP_NUM_PE);

    ctrl_state_t     state;
    logic            aw_w_ready;
    logic            wr_fire;
    logic            rd_fire;
    logic            start_pend;
    logic            busy;
    logic            done;
    logic            is_sample;
    logic [DW-1:0]   rd_mux;

    assign awready = aw_w_ready;
    assign wready = aw_w_ready;
    assign wr_fire = aw_w_ready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // pending start counts as busy so a second start is dropped
    assign busy = start_pend || (state == ctrl_fill_s) || (state == ctrl_shift_s);
    assign done = (state == ctrl_done_s) && !start_pend;

    // sample window is aligned, low address bits give the index
    assign is_sample = (awaddr >= SAMPLE_ADDR) && (awaddr < SAMPLE_END);
    assign sample_we = wr_fire && is_sample && (&wstrb[1:0]);
    assign sample_addr = awaddr[2 +: $bits(ptr_t)];
    assign sample_data = wdata[15:0];

    // write channel, one transfer in flight
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            aw_w_ready <= 1'b0;
            bvalid <= 1'b0;
            accu_base <= '0;
        end
        else
        begin
            aw_w_ready <= awvalid && wvalid && !bvalid && !aw_w_ready;
            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (wr_fire && (awaddr == BASE_ADDR))
            begin
                if (wstrb[0])
                    accu_base[7:0] <= wdata[7:0];
                if (wstrb[1])
                    accu_base[$bits(accu_t)-1:8] <= wdata[$bits(accu_t)-1:8];
            end
        end
    end

    // run sequencer
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ctrl_idle_s;
            start_pend <= 1'b0;
            fill_kick <= 1'b0;
            shift_kick <= 1'b0;
        end
        else
        begin
            fill_kick <= 1'b0;
            shift_kick <= 1'b0;
            case (state)
                ctrl_fill_s:
                    if (fill_done)
                    begin
                        state <= ctrl_shift_s;
                        shift_kick <= 1'b1;
                    end
                ctrl_shift_s:
                    if (shift_done)
                        state <= ctrl_done_s;
                default:
                    if (start_pend)
                    begin
                        state <= ctrl_fill_s;
                        fill_kick <= 1'b1;
                        start_pend <= 1'b0;
                    end
            endcase
            // start lands one cycle after bvalid rises
            if (wr_fire && (awaddr == CTRL_ADDR) && wstrb[0] && wdata[0] && !busy)
                start_pend <= 1'b1;
        end
    end

    always_comb
    begin
        rd_mux = '0;
        if (araddr == BASE_ADDR)
            rd_mux = DW'(accu_base);
        else if (araddr == STATUS_ADDR)
            rd_mux = DW'({done, busy});
        else if ((araddr >= RESULT_ADDR) && (araddr < RESULT_END))
            rd_mux = sums[araddr[2 +: PE_SEL_W]];
    end

    // read channel, held until rready
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end
        else
        begin
            arready <= arvalid && !rvalid && !arready;
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_fire)
            rdata <= rd_mux;
    end

endmodule

`default_nettype wire

// ==== verilog/nabp_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nabp_defines.svh"

module nabp_shifter
    import nabp_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  logic         fill_kick,
    input  logic         shift_kick,
    input  accu_t        accu_base,
    output logic         fill_done,
    output logic         shift_done,
    nabp_shift_if.source shift
);

    localparam int ACCU_W = $bits(accu_t);

    // fill walks the pointer to the last tap, shift covers every pixel
    localparam cnt_t FILL_CNT_INIT = cnt_t'(`NABP_TAP_STEP * (`NABP_NUM_PE - 1));
    localparam cnt_t SHIFT_CNT_INIT = cnt_t'(`NABP_IMAGE_SIZE - 1);

    shifter_state_t state;
    shifter_state_t next_state;
    cnt_t           cnt;
    accu_t          accu;
    accu_t          accu_next;
    logic           fill_last;
    logic           shift_last;
    logic           mp_en;
    logic           lb_en_d;
    logic [1:0]     pe_en_d;
    logic [1:0]     done_d;

    // wraps harmlessly, only the integer boundary matters
    assign accu_next = accu + accu_base;

    assign fill_last = (state == fill_s) && (cnt == '0);
    assign shift_last = (state == shift_s) && (cnt == '0);

    assign mp_en = ((state == fill_s) && !fill_last) ||
                   ((state == shift_s) &&
                    (accu_next[ACCU_W-1 -: `NABP_ACCU_INT] != accu[ACCU_W-1 -: `NABP_ACCU_INT]));

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (fill_kick)
                    next_state = fill_s;
            fill_s:
                if (fill_last)
                    next_state = fill_done_s;
            fill_done_s:
                if (shift_kick)
                    next_state = shift_s;
            shift_s:
                if (shift_last)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= ready_s;
        else
            state <= next_state;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cnt <= FILL_CNT_INIT;
            accu <= '0;
        end
        else
        begin
            case (state)
                fill_s:
                    if (cnt != '0)
                        cnt <= cnt - cnt_t'(1);
                fill_done_s:
                    cnt <= SHIFT_CNT_INIT;
                shift_s:
                    if (cnt != '0)
                    begin
                        cnt <= cnt - cnt_t'(1);
                        accu <= accu_next;
                    end
                default:
                begin
                    cnt <= FILL_CNT_INIT;
                    accu <= '0;
                end
            endcase
        end
    end

    // address stage then read stage ahead of the PEs
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            lb_en_d <= 1'b0;
            pe_en_d <= '0;
            done_d <= '0;
        end
        else
        begin
            lb_en_d <= mp_en;
            pe_en_d <= {pe_en_d[0], state == shift_s};
            done_d <= {done_d[0], shift_last};
        end
    end

    assign fill_done = fill_last;
    assign shift_done = done_d[1];

    assign shift.kick = fill_kick;
    assign shift.mp_shift_en = mp_en;
    assign shift.lb_shift_en = lb_en_d;
    assign shift.pe_en = pe_en_d[1];
    assign shift.done = done_d[1];

endmodule

`default_nettype wire

// ==== verilog/nabp_line_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nabp_defines.svh"

module nabp_line_buffer
    import nabp_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    nabp_shift_if.line_buffer shift,
    input  logic              sample_we,
    input  ptr_t              sample_addr,
    input  sample_t           sample_data,
    output tap_vec_t          taps
);

    sample_t mem [`NABP_LINE_LEN];
    ptr_t    ptr;
    ptr_t    tap_addr [`NABP_NUM_PE];

    always_ff @(posedge clk)
    begin
        if (sample_we)
            mem[sample_addr] <= sample_data;
    end

    // read pointer, back to sample 0 at each run
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            ptr <= '0;
        else if (shift.kick)
            ptr <= '0;
        else if (shift.mp_shift_en)
            ptr <= ptr + ptr_t'(1);
    end

    // PE p trails the pointer by p tap steps, modulo the line
    always_ff @(posedge clk)
    begin
        for (int p = 0; p < `NABP_NUM_PE; p++)
        begin
            tap_addr[p] <= ptr - ptr_t'(p * `NABP_TAP_STEP);
        end
    end

    // one cycle read latency
    always_ff @(posedge clk)
    begin
        for (int p = 0; p < `NABP_NUM_PE; p++)
        begin
            taps[p] <= mem[tap_addr[p]];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/nabp_pe_array.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nabp_defines.svh"

module nabp_pe_array
    import nabp_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_n,
    nabp_shift_if.pe                    shift,
    input  tap_vec_t                    taps,
    output pix_sum_t [`NABP_NUM_PE-1:0] sums
);

    genvar p;

    generate
        for (p = 0; p < `NABP_NUM_PE; p++)
        begin : g_pe
            pix_sum_t tap_ext;

            assign tap_ext = pix_sum_t'(taps[p]);

            // sum held once the run ends, until the next kick
            always_ff @(posedge clk)
            begin
                if (!reset_n)
                    sums[p] <= '0;
                else if (shift.kick)
                    sums[p] <= '0;
                else if (shift.pe_en)
                    sums[p] <= sums[p] + tap_ext;
            end
        end
    endgenerate

endmodule

`default_nettype wire

// ==== verilog/nabp_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nabp_defines.svh"

module nabp_top
    import nabp_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [`NABP_AXI_ADDR_W-1:0]   awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [`NABP_AXI_DATA_W-1:0]   wdata,
    input  logic [`NABP_AXI_DATA_W/8-1:0] wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [`NABP_AXI_ADDR_W-1:0]   araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [`NABP_AXI_DATA_W-1:0]   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready
);

    logic                        fill_kick;
    logic                        shift_kick;
    accu_t                       accu_base;
    logic                        fill_done;
    logic                        shift_done;
    logic                        sample_we;
    ptr_t                        sample_addr;
    sample_t                     sample_data;
    tap_vec_t                    taps;
    pix_sum_t [`NABP_NUM_PE-1:0] sums;

    nabp_shift_if i_shift_if ();

    nabp_ctrl_regs i_ctrl_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .fill_kick   (fill_kick),
        .shift_kick  (shift_kick),
        .accu_base   (accu_base),
        .fill_done   (fill_done),
        .shift_done  (shift_done),
        .sample_we   (sample_we),
        .sample_addr (sample_addr),
        .sample_data (sample_data),
        .sums        (sums)
    );

    nabp_shifter i_shifter (
        .clk        (clk),
        .reset_n    (reset_n),
        .fill_kick  (fill_kick),
        .shift_kick (shift_kick),
        .accu_base  (accu_base),
        .fill_done  (fill_done),
        .shift_done (shift_done),
        .shift      (i_shift_if.source)
    );

    nabp_line_buffer i_line_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .shift       (i_shift_if.line_buffer),
        .sample_we   (sample_we),
        .sample_addr (sample_addr),
        .sample_data (sample_data),
        .taps        (taps)
    );

    nabp_pe_array i_pe_array (
        .clk     (clk),
        .reset_n (reset_n),
        .shift   (i_shift_if.pe),
        .taps    (taps),
        .sums    (sums)
    );

endmodule

`default_nettype wire

// ==== test/nabp_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module nabp_chk
(
    input logic clk,
    input logic reset_n,
    input logic fill_kick,
    input logic shift_kick,
    input logic resp_valid,
    input logic resp_ready,
    input logic pe_en
);

    // kicks last exactly one cycle
    a_fill_kick_pulse: assert property (
        @(posedge clk) disable iff (!reset_n) fill_kick |=> !fill_kick
    ) else $error("fill_kick high for more than one cycle");

    a_shift_kick_pulse: assert property (
        @(posedge clk) disable iff (!reset_n) shift_kick |=> !shift_kick
    ) else $error("shift_kick high for more than one cycle");

    // write response held until taken
    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!reset_n) resp_valid && !resp_ready |=> resp_valid
    ) else $error("bvalid dropped before bready");

    // pe_en opens two cycles into the shift state
    a_pe_en_start: assert property (
        @(posedge clk) disable iff (!reset_n) $rose(pe_en) |-> $past(shift_kick, 3)
    ) else $error("pe_en rose without a shift_kick three cycles earlier");

endmodule

bind nabp_ctrl_regs nabp_chk i_chk_ctrl (
    .clk        (clk),
    .reset_n    (reset_n),
    .fill_kick  (fill_kick),
    .shift_kick (shift_kick),
    .resp_valid (bvalid),
    .resp_ready (bready),
    .pe_en      (1'b0)
);

bind nabp_shifter nabp_chk i_chk_shifter (
    .clk        (clk),
    .reset_n    (reset_n),
    .fill_kick  (fill_kick),
    .shift_kick (shift_kick),
    .resp_valid (1'b0),
    .resp_ready (1'b0),
    .pe_en      (pe_en_d[1])
);

`default_nettype wire

// ==== test/nabp_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "nabp_defines.svh"

module nabp_tb
    import nabp_pkg::*;
();

    typedef logic [`NABP_AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`NABP_AXI_DATA_W-1:0] axi_data_t;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    localparam int LINE_LEN = `NABP_LINE_LEN;
    localparam int NUM_PE = `NABP_NUM_PE;
    // generous bound for one case, bus stalls included
    localparam int CASE_CYCLES = 1000;
    // fill, shift kick, shift, done delay and status update of one run
    localparam int RUN_CYCLES = `NABP_TAP_STEP + 1 + 1 + `NABP_IMAGE_SIZE + 2 + 1;
    // an unstalled STATUS read takes three cycles
    localparam int READ_CYCLES = 3;
    localparam int MAX_POLLS = RUN_CYCLES / READ_CYCLES + 2;
    localparam string STIM_FILE = "test/nabp_stimulus.txt";

    localparam axi_addr_t CTRL_ADDR = axi_addr_t'(`NABP_REG_CTRL);
    localparam axi_addr_t BASE_ADDR = axi_addr_t'(`NABP_REG_BASE);
    localparam axi_addr_t STATUS_ADDR = axi_addr_t'(`NABP_REG_STATUS);

    logic                          clk = 1'b0;
    logic                          reset_n;
    axi_addr_t                     awaddr;
    logic                          awvalid;
    logic                          awready;
    axi_data_t                     wdata;
    logic [`NABP_AXI_DATA_W/8-1:0] wstrb;
    logic                          wvalid;
    logic                          wready;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic                          bready;
    axi_addr_t                     araddr;
    logic                          arvalid;
    logic                          arready;
    axi_data_t                     rdata;
    logic [1:0]                    rresp;
    logic                          rvalid;
    logic                          rready;

    integer   seed;
    logic     loaded;
    int       num_cases;
    accu_t    base_q [$];
    sample_t  samp_q [$];
    pix_sum_t exp_q [$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    nabp_top i_nabp_top (
        .clk     (clk),
        .reset_n (reset_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_sum(input string name, input pix_sum_t got, input pix_sum_t exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_status(input string name, input logic [1:0] got,
                                input logic [1:0] exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // roughly one cycle in four held off when stalling
    function automatic logic ready_draw(input logic stall);
        if (!stall)
            return 1'b1;
        return (($random(seed) & 3) != 0);
    endfunction

    function automatic axi_addr_t sample_reg_addr(input int i);
        return axi_addr_t'(`NABP_REG_SAMPLE + 4 * i);
    endfunction

    function automatic axi_addr_t result_reg_addr(input int p);
        return axi_addr_t'(`NABP_REG_RESULT + 4 * p);
    endfunction

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input logic stall);
        awaddr <= addr;
        awvalid <= 1'b1;
        wdata <= data;
        wstrb <= '1;
        wvalid <= 1'b1;
        @(posedge clk);
        while (!(awready || wready))
            @(posedge clk);
        if (!(awready && wready))
            fail_run($sformatf("awready and wready did not rise together for 0x%h", addr));
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        bready <= ready_draw(stall);
        @(posedge clk);
        while (!(bvalid && bready))
        begin
            bready <= ready_draw(stall);
            @(posedge clk);
        end
        if (bresp !== 2'b00)
            fail_run($sformatf("write to 0x%h returned an error response", addr));
        bready <= 1'b0;
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data, input logic stall);
        araddr <= addr;
        arvalid <= 1'b1;
        @(posedge clk);
        while (!arready)
            @(posedge clk);
        arvalid <= 1'b0;
        rready <= ready_draw(stall);
        @(posedge clk);
        while (!(rvalid && rready))
        begin
            rready <= ready_draw(stall);
            @(posedge clk);
        end
        if (rresp !== 2'b00)
            fail_run($sformatf("read from 0x%h returned an error response", addr));
        data = rdata;
        rready <= 1'b0;
    endtask

    // poll busy, a second run would outlast the poll bound
    task automatic wait_idle();
        axi_data_t rd;
        int        polls;
        polls = 1;
        axi_read(STATUS_ADDR, rd, 1'b0);
        while (rd[0])
        begin
            if (polls >= MAX_POLLS)
                fail_run("busy outlasted one run, a start written while busy was taken");
            axi_read(STATUS_ADDR, rd, 1'b0);
            polls++;
        end
    endtask

    task automatic load_stimulus();
        int        fd;
        int        n;
        string     line;
        axi_data_t f_base;
        axi_data_t f_samp [16];
        axi_data_t f_exp [2];

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
            fail_run({"could not open the stimulus file ", STIM_FILE});
        while ($fgets(line, fd) != 0)
        begin
            // comment and blank lines carry no case
            if ((line.len() > 1) && (line.getc(0) != "#"))
            begin
                n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f_base, f_samp[0], f_samp[1], f_samp[2], f_samp[3],
                    f_samp[4], f_samp[5], f_samp[6], f_samp[7],
                    f_samp[8], f_samp[9], f_samp[10], f_samp[11],
                    f_samp[12], f_samp[13], f_samp[14], f_samp[15],
                    f_exp[0], f_exp[1]);
                if (n != 19)
                    fail_run({"stimulus line has the wrong number of fields: ", line});
                base_q.push_back(accu_t'(f_base));
                for (int i = 0; i < LINE_LEN; i++)
                    samp_q.push_back(sample_t'(f_samp[i]));
                for (int p = 0; p < NUM_PE; p++)
                    exp_q.push_back(pix_sum_t'(f_exp[p]));
            end
        end
        $fclose(fd);
        num_cases = base_q.size();
        if (num_cases == 0)
            fail_run("the stimulus file holds no test case");
    endtask

    task automatic run_case(input int c);
        axi_data_t rd;

        axi_write(BASE_ADDR, axi_data_t'(base_q[c]), 1'b1);
        for (int i = 0; i < LINE_LEN; i++)
            axi_write(sample_reg_addr(i), axi_data_t'(samp_q[c * LINE_LEN + i]), 1'b1);

        // second start lands mid-run and has to be dropped
        axi_write(CTRL_ADDR, 32'h1, 1'b0);
        axi_write(CTRL_ADDR, 32'h1, 1'b0);
        axi_read(STATUS_ADDR, rd, 1'b0);
        check_status($sformatf("status busy, case %0d", c), rd[1:0], 2'b01);

        wait_idle();
        axi_read(STATUS_ADDR, rd, 1'b0);
        check_status($sformatf("status done, case %0d", c), rd[1:0], 2'b10);

        // each sum read plain, then again under rready stalls
        for (int p = 0; p < NUM_PE; p++)
        begin
            axi_read(result_reg_addr(p), rd, 1'b0);
            check_sum($sformatf("sums[%0d], case %0d", p, c), pix_sum_t'(rd),
                      exp_q[c * NUM_PE + p]);
            axi_read(result_reg_addr(p), rd, 1'b1);
            check_sum($sformatf("sums[%0d] stalled, case %0d", p, c), pix_sum_t'(rd),
                      exp_q[c * NUM_PE + p]);
        end
    endtask

    initial
    begin
        longint limit_ns;
        wait (loaded === 1'b1);
        limit_ns = longint'(RESET_CYCLES + (num_cases + 1) * CASE_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        fail_run($sformatf("watchdog expired, the run took longer than %0d ns", limit_ns));
    end

    initial
    begin
        axi_data_t rd;

        seed = 32'heef8;
        loaded = 1'b0;
        reset_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;

        load_stimulus();
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        // idle controller and cleared sums
        axi_read(STATUS_ADDR, rd, 1'b0);
        check_status("status after reset", rd[1:0], 2'b00);
        for (int p = 0; p < NUM_PE; p++)
        begin
            axi_read(result_reg_addr(p), rd, 1'b0);
            check_sum($sformatf("sums[%0d] after reset", p), pix_sum_t'(rd), '0);
        end

        for (int c = 0; c < num_cases; c++)
            run_case(c);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/nabp_stimulus.txt ====
# base s0 s1 .. s15 sum_pe0 sum_pe1, every field hex, one run per line
# sums follow sample[(4 + floor(k*base/256) - 4p) mod 16] over k = 0..7
100 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 100 440 240
060 11 22 33 44 101 202 303 404 505 606 707 808 909 a0a b0b c0c f0f ff
0c8 1000 1010 1020 1030 1040 1050 1060 1070 1080 1090 10a0 10b0 10c0 10d0 10e0 10f0 8320 8120
000 1234 1 2 3 ffff 5 6 7 8 9 a b c d e f 7fff8 91a0
040 abc def 9999 9999 1111 2222 9999 9999 9999 9999 9999 9999 9999 9999 9999 9999 cccc 62ac
0ff 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 100 3d0 1d0
080 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 100 340 140

// ==== verilog.f ====
+incdir+verilog
verilog/nabp_pkg.sv
verilog/nabp_shift_if.sv
verilog/nabp_ctrl_regs.sv
verilog/nabp_shifter.sv
verilog/nabp_line_buffer.sv
verilog/nabp_pe_array.sv
verilog/nabp_top.sv
test/nabp_chk.sv
test/nabp_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := nabp_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard verilog/*.svh)
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# simulator exit status is the verdict
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
